/* compile.f */
logic/muldiv_pkg.sv
logic/div_unsigned.sv
logic/div_signed.sv
logic/mul_shift_add.sv
logic/result_arbiter.sv
logic/muldiv_unit.sv
tb/muldiv_assert.sv
tb/muldiv_tb.sv

/* logic/div_signed.sv */
module div_signed (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         grant,
    input  logic [muldiv_pkg::op_w-1:0]  op,
    input  logic [muldiv_pkg::tag_w-1:0] tag,
    input  logic [muldiv_pkg::xlen-1:0]  rs1,
    input  logic [muldiv_pkg::xlen-1:0]  rs2,
    output logic                         ready,
    output logic                         done,
    output logic                         error,
    output logic [muldiv_pkg::xlen-1:0]  value,
    output logic [muldiv_pkg::tag_w-1:0] tag_out
);
    import muldiv_pkg::*;

    logic            signed_op;
    logic            rem_op;
    logic            u_start;
    logic            u_grant;
    logic            u_done;
    logic            u_error;
    logic [xlen-1:0] u_dividend;
    logic [xlen-1:0] u_divisor;
    logic [xlen-1:0] u_quotient;
    logic [xlen-1:0] u_remainder;
    logic            rem_sel;
    logic            neg_q;
    logic            neg_r;
    logic [xlen-1:0] q_fixed;
    logic [xlen-1:0] r_fixed;

    assign signed_op = (op == op_div) || (op == op_rem);
    assign rem_op    = (op == op_rem) || (op == op_remu);

    // The unsigned core only ever sees magnitudes.
    assign u_dividend = (signed_op && rs1[xlen-1]) ? -rs1 : rs1;
    assign u_divisor  = (signed_op && rs2[xlen-1]) ? -rs2 : rs2;
    assign u_start    = start;
    assign u_grant    = grant;

    always_ff @(posedge clk) begin
        if (start && ready) begin
            tag_out <= tag;
            rem_sel <= rem_op;
            neg_q   <= signed_op && (rs1[xlen-1] ^ rs2[xlen-1]);
            neg_r   <= signed_op && rs1[xlen-1]; // Remainder takes the sign of the dividend.
        end
    end

    // A zero divisor must leave the all-ones quotient untouched.
    assign q_fixed = (neg_q && !u_error) ? -u_quotient : u_quotient;
    assign r_fixed = neg_r ? -u_remainder : u_remainder;
    assign value   = rem_sel ? r_fixed : q_fixed;
    assign done    = u_done;
    assign error   = u_error;

    div_unsigned i_div_unsigned (
        .clk       (clk),
        .reset     (reset),
        .start     (u_start),
        .grant     (u_grant),
        .dividend  (u_dividend),
        .divisor   (u_divisor),
        .ready     (ready),
        .done      (u_done),
        .error     (u_error),
        .quotient  (u_quotient),
        .remainder (u_remainder)
    );

endmodule

/* logic/div_unsigned.sv */
module div_unsigned (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        grant,
    input  logic [muldiv_pkg::xlen-1:0] dividend,
    input  logic [muldiv_pkg::xlen-1:0] divisor,
    output logic                        ready,
    output logic                        done,
    output logic                        error,
    output logic [muldiv_pkg::xlen-1:0] quotient,
    output logic [muldiv_pkg::xlen-1:0] remainder
);
    import muldiv_pkg::*;

    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_divide    = 2'd1;
    localparam logic [1:0] st_end       = 2'd2;
    localparam logic [1:0] st_end_error = 2'd3;

    logic [1:0]        state;
    logic [xlen-1:0]   count;           // One-hot weight of the current quotient bit.
    logic [2*xlen-1:0] shifted_divisor;
    logic              take;

    assign ready = state == st_idle;
    assign done  = (state == st_end) || (state == st_end_error);
    assign error = state == st_end_error;

    // The full double-width compare keeps high divisor bits from being lost.
    assign take = {{xlen{1'b0}}, remainder} >= shifted_divisor;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        if (divisor == '0) begin
                            state <= st_end_error;
                        end else if (divisor > dividend) begin
                            state <= st_end;
                        end else begin
                            state <= st_divide;
                        end
                    end
                end
                st_divide: begin
                    if (count[0]) begin
                        state <= st_end; // Last quotient bit is resolved in this cycle.
                    end
                end
                default: begin
                    if (grant) begin
                        state <= st_idle; // Results stay put until the arbiter takes them.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            remainder       <= dividend;
            quotient        <= (divisor == '0) ? '1 : '0;
            shifted_divisor <= {1'b0, divisor, {(xlen-1){1'b0}}};
            count           <= {1'b1, {(div_steps-1){1'b0}}};
        end else if (state == st_divide) begin
            if (take) begin
                remainder <= remainder - shifted_divisor[xlen-1:0];
                quotient  <= quotient | count;
            end
            shifted_divisor <= shifted_divisor >> 1;
            count           <= count >> 1;
        end
    end

endmodule

/* logic/mul_shift_add.sv */
module mul_shift_add (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         grant,
    input  logic [muldiv_pkg::op_w-1:0]  op,
    input  logic [muldiv_pkg::tag_w-1:0] tag,
    input  logic [muldiv_pkg::xlen-1:0]  rs1,
    input  logic [muldiv_pkg::xlen-1:0]  rs2,
    output logic                         ready,
    output logic                         done,
    output logic [muldiv_pkg::xlen-1:0]  value,
    output logic [muldiv_pkg::tag_w-1:0] tag_out
);
    import muldiv_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_run  = 2'd1;
    localparam logic [1:0] st_fix  = 2'd2;
    localparam logic [1:0] st_done = 2'd3;
    localparam int count_w = $clog2(mul_steps);

    logic [1:0]        state;
    logic [count_w-1:0] count;
    logic              a_signed;
    logic              b_signed;
    logic [xlen-1:0]   abs_a;
    logic [xlen-1:0]   abs_b;
    logic [2*xlen-1:0] mcand;
    logic [2*xlen-1:0] acc;
    logic [2*xlen-1:0] product;
    logic [xlen-1:0]   mplier;
    logic              neg;
    logic              hi_sel;

    assign a_signed = (op == op_mulh) || (op == op_mulhsu);
    assign b_signed = op == op_mulh;
    assign abs_a    = (a_signed && rs1[xlen-1]) ? -rs1 : rs1;
    assign abs_b    = (b_signed && rs2[xlen-1]) ? -rs2 : rs2;
    assign product  = neg ? -acc : acc;
    assign ready    = state == st_idle;
    assign done     = state == st_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (start) state <= st_run;
                st_run:  if (count == '0) state <= st_fix;
                st_fix:  state <= st_done;
                default: if (grant) state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            acc     <= abs_b[0] ? {{xlen{1'b0}}, abs_a} : '0; // First step happens at start.
            mcand   <= {{(xlen-1){1'b0}}, abs_a, 1'b0};
            mplier  <= abs_b >> 1;
            count   <= count_w'(mul_steps - 2);
            neg     <= (a_signed && rs1[xlen-1]) ^ (b_signed && rs2[xlen-1]);
            hi_sel  <= op != op_mul;
            tag_out <= tag;
        end else if (state == st_run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            count  <= count - 1'b1;
        end else if (state == st_fix) begin
            value <= hi_sel ? product[2*xlen-1:xlen] : product[xlen-1:0];
        end
    end

endmodule

/* logic/muldiv_pkg.sv */
package muldiv_pkg;

    // Operand and result width.
    localparam int xlen = 32;

    // Width of the request tag that travels with each result.
    localparam int tag_w = 4;

    // Operation codes are the RV32M funct3 values.
    localparam int op_w = 3;

    localparam logic [op_w-1:0] op_mul    = 3'd0;
    localparam logic [op_w-1:0] op_mulh   = 3'd1;
    localparam logic [op_w-1:0] op_mulhsu = 3'd2;
    localparam logic [op_w-1:0] op_mulhu  = 3'd3;
    localparam logic [op_w-1:0] op_div    = 3'd4; // Bit 2 marks the divide group.
    localparam logic [op_w-1:0] op_divu   = 3'd5; // Bit 0 marks unsigned.
    localparam logic [op_w-1:0] op_rem    = 3'd6; // Bit 1 marks remainder.
    localparam logic [op_w-1:0] op_remu   = 3'd7;

    // Iteration counts of the two engines.
    localparam int div_steps = xlen;
    localparam int mul_steps = xlen;

endpackage

/* logic/muldiv_unit.sv */
module muldiv_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic [muldiv_pkg::op_w-1:0]  op,
    input  logic [muldiv_pkg::tag_w-1:0] tag,
    input  logic [muldiv_pkg::xlen-1:0]  rs1,
    input  logic [muldiv_pkg::xlen-1:0]  rs2,
    output logic                         mul_ready,
    output logic                         div_ready,
    output logic                         result_valid,
    output logic [muldiv_pkg::xlen-1:0]  result,
    output logic [muldiv_pkg::tag_w-1:0] result_tag,
    output logic                         result_error
);
    import muldiv_pkg::*;

    logic             mul_start;
    logic             div_start;
    logic             mul_done;
    logic             div_done;
    logic             div_error;
    logic             mul_grant;
    logic             div_grant;
    logic [xlen-1:0]  mul_value;
    logic [xlen-1:0]  div_value;
    logic [tag_w-1:0] mul_tag_out;
    logic [tag_w-1:0] div_tag_out;

    // A request to a busy engine is dropped here.
    assign div_start = start && op[2] && div_ready;
    assign mul_start = start && !op[2] && mul_ready;

    div_signed i_div_signed (
        .clk (clk), .reset (reset), .start (div_start), .grant (div_grant),
        .op (op), .tag (tag), .rs1 (rs1), .rs2 (rs2),
        .ready (div_ready), .done (div_done), .error (div_error),
        .value (div_value), .tag_out (div_tag_out)
    );

    mul_shift_add i_mul_shift_add (
        .clk (clk), .reset (reset), .start (mul_start), .grant (mul_grant),
        .op (op), .tag (tag), .rs1 (rs1), .rs2 (rs2),
        .ready (mul_ready), .done (mul_done),
        .value (mul_value), .tag_out (mul_tag_out)
    );

    result_arbiter i_result_arbiter (
        .clk (clk), .reset (reset),
        .mul_done (mul_done), .div_done (div_done), .div_error (div_error),
        .mul_value (mul_value), .div_value (div_value),
        .mul_tag_out (mul_tag_out), .div_tag_out (div_tag_out),
        .mul_grant (mul_grant), .div_grant (div_grant),
        .result_valid (result_valid), .result_error (result_error),
        .result (result), .result_tag (result_tag)
    );

endmodule

/* logic/result_arbiter.sv */
module result_arbiter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         mul_done,
    input  logic                         div_done,
    input  logic                         div_error,
    input  logic [muldiv_pkg::xlen-1:0]  mul_value,
    input  logic [muldiv_pkg::xlen-1:0]  div_value,
    input  logic [muldiv_pkg::tag_w-1:0] mul_tag_out,
    input  logic [muldiv_pkg::tag_w-1:0] div_tag_out,
    output logic                         mul_grant,
    output logic                         div_grant,
    output logic                         result_valid,
    output logic                         result_error,
    output logic [muldiv_pkg::xlen-1:0]  result,
    output logic [muldiv_pkg::tag_w-1:0] result_tag
);

    logic mul_grant_q;
    logic div_grant_q;

    // An engine just granted is skipped for one cycle while its done drops.
    assign div_grant = div_done && !div_grant_q;
    assign mul_grant = mul_done && !mul_grant_q && !div_grant; // Divider wins ties.

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_grant_q  <= 1'b0;
            div_grant_q  <= 1'b0;
            result_valid <= 1'b0;
            result_error <= 1'b0;
        end else begin
            mul_grant_q  <= mul_grant;
            div_grant_q  <= div_grant;
            result_valid <= mul_grant || div_grant;
            result_error <= div_grant && div_error;
        end
    end

    always_ff @(posedge clk) begin
        if (div_grant) begin
            result     <= div_value;
            result_tag <= div_tag_out;
        end else if (mul_grant) begin
            result     <= mul_value;
            result_tag <= mul_tag_out;
        end
    end

endmodule

/* tb/muldiv_assert.sv */
module muldiv_assert (
    input logic clk,
    input logic reset,
    input logic mul_ready,
    input logic div_ready,
    input logic result_valid,
    input logic result_error
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0; // Number of assertion failures seen so far.

    error_with_valid: assert property (@(posedge clk) disable iff (reset)
        result_error |-> result_valid)
        else begin
            failures++;
            $error("result_error is high without result_valid.");
        end

    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> mul_ready && div_ready)
        else begin
            failures++;
            $error("An engine is not ready in the first cycle after reset.");
        end

    valid_low_in_reset: assert property (@(posedge clk) reset |=> !result_valid)
        else begin
            failures++;
            $error("result_valid is high during reset.");
        end

endmodule

bind muldiv_unit muldiv_assert i_muldiv_assert (
    .clk          (clk),
    .reset        (reset),
    .mul_ready    (mul_ready),
    .div_ready    (div_ready),
    .result_valid (result_valid),
    .result_error (result_error)
);

/* tb/muldiv_tb.sv */
module muldiv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    localparam int random_count    = 200;
    localparam int traffic_count   = 100;
    localparam int total_requests  = random_count + traffic_count + 20;
    localparam int watchdog_cycles = total_requests * 40 + 500;

    logic                clk;
    logic                reset;
    logic                start;
    logic [op_w-1:0]     op;
    logic [tag_w-1:0]    tag;
    logic [xlen-1:0]     rs1;
    logic [xlen-1:0]     rs2;
    logic                mul_ready;
    logic                div_ready;
    logic                result_valid;
    logic                result_error;
    logic [xlen-1:0]     result;
    logic [tag_w-1:0]    result_tag;
    logic [31:0]         lfsr = 32'hba02;
    logic [xlen-1:0]     exp_value [2**tag_w];
    logic                exp_error [2**tag_w];
    logic [2**tag_w-1:0] pending;   // One bit per tag that is still in flight.
    logic [tag_w-1:0]    next_tag;
    logic [op_w-1:0]     r_op;
    logic [xlen-1:0]     r_a;
    logic [xlen-1:0]     r_b;
    int                  pass_count;
    int                  fail_count;
    int                  result_count;
    int                  result_base;
    int                  test_fail_base;
    string               test_name;

    muldiv_unit i_muldiv_unit (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * 10);
        $display("Watchdog expired in test %s with results still missing.", test_name);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Returns the error flag above the 32-bit result.
    function automatic logic [32:0] reference_result(input logic [op_w-1:0] o,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] q;
        logic signed [63:0] r;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (o)
            op_mulh:   p = sa * sb;
            op_mulhsu: p = sa * $signed(ub);
            default:   p = ua * ub;
        endcase
        if (!o[2]) return {1'b0, (o == op_mul) ? p[31:0] : p[63:32]};
        if (b == '0) return {1'b1, o[1] ? a : 32'hffff_ffff};
        if (o[0]) return {1'b0, o[1] ? a % b : a / b};
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return {1'b0, o[1] ? 32'h0 : a};
        q = sa / sb;
        r = sa % sb;
        return {1'b0, o[1] ? r[31:0] : q[31:0]};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pick_random();
        r_op = op_w'(take_bits(op_w));
        r_a  = take_bits(xlen);
        r_b  = take_bits(1) ? take_bits(xlen) : take_bits(6); // Small divisors give long divides.
    endtask

    task automatic issue(input logic [op_w-1:0] o, input logic [xlen-1:0] a,
                         input logic [xlen-1:0] b);
        while (pending[next_tag] || !(o[2] ? div_ready : mul_ready)) begin
            next_cycle();
        end
        {exp_error[next_tag], exp_value[next_tag]} = reference_result(o, a, b);
        pending[next_tag] = 1'b1;
        start = 1'b1;
        op    = o;
        tag   = next_tag;
        rs1   = a;
        rs2   = b;
        next_cycle();
        start    = 1'b0;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain();
        while (pending != '0) begin
            next_cycle();
        end
    endtask

    task automatic run_one(input logic [op_w-1:0] o, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b);
        issue(o, a, b);
        drain();
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_fail_base = fail_count;
        result_base    = result_count;
    endtask

    task automatic end_test();
        $display("%-14s finished with %0d errors", test_name, fail_count - test_fail_base);
    endtask

    task automatic check_count(input int expected);
        if (result_count - result_base != expected) begin
            $display("Error %s result count: expected %0d actual %0d", test_name, expected,
                     result_count - result_base);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    always @(negedge clk) begin : compare
        if (!reset && result_valid) begin
            result_count++;
            if (!pending[result_tag]) begin
                $display("In %s a result came back with tag %0d, which was not in flight.",
                         test_name, result_tag);
                fail_count++;
            end else if (result !== exp_value[result_tag] ||
                         result_error !== exp_error[result_tag]) begin
                $display("Error %s tag %0d: expected %h error %b actual %h error %b",
                         test_name, result_tag, exp_value[result_tag], exp_error[result_tag],
                         result, result_error);
                fail_count++;
            end else begin
                pass_count++;
            end
            pending[result_tag] = 1'b0;
        end
    end

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        op           = '0;
        tag          = '0;
        rs1          = '0;
        rs2          = '0;
        pending      = '0;
        next_tag     = '0;
        pass_count   = 0;
        fail_count   = 0;
        result_count = 0;
        test_name    = "reset_state";
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        begin_test("reset_state");
        next_cycle();
        if (mul_ready !== 1'b1 || div_ready !== 1'b1 || result_valid !== 1'b0) begin
            $display("Error reset_state: expected ready 11 valid 0 actual ready %b%b valid %b",
                     mul_ready, div_ready, result_valid);
            fail_count++;
        end else begin
            pass_count++;
        end
        end_test();

        begin_test("random_arith");
        for (int i = 0; i < random_count; i++) begin
            pick_random();
            run_one(r_op, r_a, r_b);
        end
        end_test();

        begin_test("div_corners");
        run_one(op_div, 32'h1234_5678, 32'h0);
        run_one(op_divu, 32'hdead_beef, 32'h0);
        run_one(op_rem, 32'h8765_4321, 32'h0);
        run_one(op_remu, 32'h0000_0042, 32'h0);
        run_one(op_div, 32'h8000_0000, 32'hffff_ffff);
        run_one(op_rem, 32'h8000_0000, 32'hffff_ffff);
        run_one(op_divu, 32'd3, 32'd1000);
        run_one(op_div, 32'hffff_fff9, 32'h1234_5678);
        run_one(op_remu, 32'd5, 32'hffff_ffff);
        end_test();

        begin_test("concurrency");
        issue(op_mulhu, 32'hffff_fff0, 32'h0000_1234);
        issue(op_div, 32'h7fff_0000, 32'h0000_0123);
        if (mul_ready !== 1'b0 || div_ready !== 1'b0) begin
            $display("Error concurrency ready: expected 00 actual %b%b", mul_ready, div_ready);
            fail_count++;
        end
        start = 1'b1; // Sent to the busy multiplier, which must drop it.
        op    = op_mulh;
        tag   = next_tag;
        next_cycle();
        start = 1'b0;
        drain();
        // The trivial divide is timed to finish in the same cycle as the multiply.
        issue(op_mul, 32'h0001_0003, 32'hfffe_0007);
        repeat (31) next_cycle();
        issue(op_divu, 32'd9, 32'd100);
        drain();
        repeat (40) next_cycle();
        check_count(4);
        end_test();

        begin_test("mixed_traffic");
        for (int i = 0; i < traffic_count; i++) begin
            pick_random();
            issue(r_op, r_a, r_b);
        end
        drain();
        check_count(traffic_count);
        end_test();

        fail_count += i_muldiv_unit.i_muldiv_assert.failures;
        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
